//--- common/cpuConsts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

////////////////////////////////////////
// Memory geometry
////////////////////////////////////////

// Instruction memory is 1024 words
`define INSTR_ADDR_BITS 10
// Data RAM is 256 words
`define DATA_ADDR_BITS 8
`define REG_COUNT 16

////////////////////////////////////////
// Memory mapped I/O
////////////////////////////////////////

// High byte of the I/O page
`define IO_PAGE 8'hFF
`define IO_IN_ADDR 16'hFF01
`define IO_OUT_ADDR 16'hFF00

`endif

//--- common/isaPkg.sv
`include "cpuConsts.svh"

package isaPkg;

	// Full instruction word
	typedef logic [17:0] instrWord;

	typedef logic [`INSTR_ADDR_BITS-1:0] instrAddr;

	// Immediate field, also the branch target field
	typedef logic [9:0] imm10;

	// Opcode in bits 17..14
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		SHL  = 4'd5,
		SHR  = 4'd6,
		ADDI = 4'd7,
		LDI  = 4'd8,
		LD   = 4'd9,
		ST   = 4'd10,
		BR   = 4'd11,
		CALL = 4'd12,
		RET  = 4'd13,
		HALT = 4'd14,
		NOP  = 4'd15
	} opcode;

	// Branch condition in bits 13..12
	typedef enum logic [1:0] {
		condAlways  = 2'd0,
		condZero    = 2'd1,
		condNotZero = 2'd2,
		condCarry   = 2'd3
	} branchCond;

endpackage

//--- common/datapathPkg.sv
`include "cpuConsts.svh"

package datapathPkg;

	typedef logic [15:0] dataWord;
	typedef logic [3:0] regIndex;
	typedef logic [`DATA_ADDR_BITS-1:0] dataAddr;

	// Bit 2 carry, bit 1 negative, bit 0 zero
	typedef logic [2:0] flagBits;

	// Same order as the first seven opcodes
	typedef enum logic [2:0] {
		aluAdd  = 3'd0,
		aluSub  = 3'd1,
		aluAnd  = 3'd2,
		aluOr   = 3'd3,
		aluXor  = 3'd4,
		aluShl  = 3'd5,
		aluShr  = 3'd6,
		aluPass = 3'd7
	} aluOpType;

	// Register writeback source
	typedef enum logic [1:0] {
		wbAlu       = 2'd0,
		wbImmediate = 2'd1,
		wbMemory    = 2'd2
	} wbSourceType;

endpackage

//--- control/controlUnit.sv
module controlUnit import isaPkg::*, datapathPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  instrWord    instr,
	input  flagBits     flags,
	output regIndex     readSel1,
	output regIndex     readSel2,
	output regIndex     destSel,
	output logic        regWriteEn,
	output wbSourceType wbSource,
	output dataWord     immediate,
	output aluOpType    aluOp,
	output logic        flagWrite,
	output logic        memRead,
	output logic        memWrite,
	output logic        hold,
	output logic        jumpEn,
	output logic        callEn,
	output logic        retEn,
	output instrAddr    jumpTarget,
	output logic        halted
);

	typedef enum logic [1:0] {run, loadWait, stopped} ctrlState;

	ctrlState  state;
	ctrlState  nextState;
	opcode     op;
	branchCond cond;
	imm10      immField;
	logic      condMet;

	////////////////////////////////////////
	// Field decode
	////////////////////////////////////////

	assign op = opcode'(instr[17:14]);
	assign cond = branchCond'(instr[13:12]);
	assign immField = instr[9:0];
	assign jumpTarget = instr[9:0];
	assign destSel = instr[13:10];

	// ADDI reads its own destination as the first operand
	assign readSel1 = (op == ADDI) ? instr[13:10] : instr[9:6];
	assign readSel2 = instr[5:2];

	// Sign extend for ADDI, zero extend for LDI
	assign immediate = (op == ADDI) ? {{6{immField[9]}}, immField} : {6'b0, immField};

	assign halted = (state == stopped);

	always_comb begin
		unique case (cond)
			condAlways:  condMet = 1'b1;
			condZero:    condMet = flags[0];
			condNotZero: condMet = !flags[0];
			condCarry:   condMet = flags[2];
		endcase
	end

	always_comb begin
		unique case (op)
			ADD, ADDI: aluOp = aluAdd;
			SUB:       aluOp = aluSub;
			AND:       aluOp = aluAnd;
			OR:        aluOp = aluOr;
			XOR:       aluOp = aluXor;
			SHL:       aluOp = aluShl;
			SHR:       aluOp = aluShr;
			default:   aluOp = aluPass;
		endcase
	end

	////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////

	always_comb begin
		nextState = state;
		regWriteEn = 1'b0;
		wbSource = wbAlu;
		flagWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		hold = 1'b0;
		jumpEn = 1'b0;
		callEn = 1'b0;
		retEn = 1'b0;
		unique case (state)
			run: begin
				unique case (op)
					ADD, SUB, AND, OR, XOR, SHL, SHR, ADDI: begin
						regWriteEn = 1'b1;
						flagWrite = 1'b1;
					end
					LDI: begin
						regWriteEn = 1'b1;
						wbSource = wbImmediate;
					end
					LD: begin
						// Issue the read, keep the pc for one more cycle
						memRead = 1'b1;
						hold = 1'b1;
						nextState = loadWait;
					end
					ST:   memWrite = 1'b1;
					BR:   jumpEn = condMet;
					CALL: callEn = 1'b1;
					RET:  retEn = 1'b1;
					HALT: begin
						hold = 1'b1;
						nextState = stopped;
					end
					NOP: ;
				endcase
			end
			loadWait: begin
				// RAM data is valid now
				regWriteEn = 1'b1;
				wbSource = wbMemory;
				nextState = run;
			end
			stopped: hold = 1'b1;
			default: nextState = run;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= run;
		end else begin
			state <= nextState;
		end
	end

	// Halt is sticky and nothing is written after it
	noWriteWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted && !regWriteEn);

endmodule

//--- logic/executeUnit.sv
module executeUnit import datapathPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  dataWord  a,
	input  dataWord  b,
	input  aluOpType aluOp,
	input  logic     flagWrite,
	output dataWord  result,
	output flagBits  flags
);

	logic        carryNext;
	logic [16:0] sum;

	always_comb begin
		carryNext = 1'b0;
		sum = '0;
		unique case (aluOp)
			aluAdd: begin
				sum = {1'b0, a} + {1'b0, b};
				result = sum[15:0];
				carryNext = sum[16];
			end
			aluSub: begin
				result = a - b;
				// Borrow
				carryNext = (a < b);
			end
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			// Shift amount is the low nibble only
			aluShl: result = a << b[3:0];
			aluShr: result = a >> b[3:0];
			aluPass: result = b;
		endcase
	end

	////////////////////////////////////////
	// Flag register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			flags <= '0;
		end else if (flagWrite) begin
			flags <= {carryNext, result[15], result == '0};
		end
	end

endmodule

//--- logic/registerFile.sv
`include "cpuConsts.svh"

module registerFile import datapathPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  regIndex readSel1,
	input  regIndex readSel2,
	output dataWord readData1,
	output dataWord readData2,
	input  regIndex destSel,
	input  logic    writeEn,
	input  dataWord writeData
);

	dataWord regs [`REG_COUNT];

	// Asynchronous read ports
	assign readData1 = regs[readSel1];
	assign readData2 = regs[readSel2];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[destSel] <= writeData;
		end
	end

endmodule

//--- logic/fetchUnit.sv
module fetchUnit import isaPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     hold,
	input  logic     jumpEn,
	input  logic     callEn,
	input  logic     retEn,
	input  instrAddr jumpTarget,
	output instrAddr pc
);

	instrAddr pcNext;
	instrAddr pcPlusOne;
	// One-deep return stack
	instrAddr returnAddr;

	assign pcPlusOne = pc + 1'b1;

	always_comb begin
		if (hold) begin
			pcNext = pc;
		end else if (retEn) begin
			pcNext = returnAddr;
		end else if (jumpEn || callEn) begin
			pcNext = jumpTarget;
		end else begin
			pcNext = pcPlusOne;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			returnAddr <= '0;
		end else begin
			pc <= pcNext;
			if (callEn) begin
				returnAddr <= pcPlusOne;
			end
		end
	end

	callRetExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(callEn && retEn));

endmodule

//--- memory/memoryController.sv
`include "cpuConsts.svh"

module memoryController import datapathPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  dataWord accessAddr,
	input  dataWord writeData,
	input  logic    memRead,
	input  logic    memWrite,
	input  dataWord ramReadData,
	input  dataWord inValue,
	output dataAddr ramAddr,
	output dataWord ramWriteData,
	output logic    ramWriteEn,
	output dataWord readData,
	output dataWord outValue,
	output logic    outStrobe
);

	logic inIoPage;
	logic isOutAddr;
	logic isInAddr;
	// Source of the read in flight
	logic pendingIo;
	logic pendingIn;

	assign inIoPage = (accessAddr[15:8] == `IO_PAGE);
	assign isOutAddr = (accessAddr == `IO_OUT_ADDR);
	assign isInAddr = (accessAddr == `IO_IN_ADDR);

	// The I/O page never reaches the RAM
	assign ramAddr = accessAddr[`DATA_ADDR_BITS-1:0];
	assign ramWriteData = writeData;
	assign ramWriteEn = memWrite && !inIoPage;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pendingIo <= 1'b0;
			pendingIn <= 1'b0;
		end else if (memRead) begin
			pendingIo <= inIoPage;
			pendingIn <= isInAddr;
		end
	end

	// Unmapped I/O words read as zero
	always_comb begin
		if (pendingIn) begin
			readData = inValue;
		end else if (pendingIo) begin
			readData = '0;
		end else begin
			readData = ramReadData;
		end
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outStrobe <= 1'b0;
		end else begin
			outStrobe <= memWrite && isOutAddr;
		end
	end

	always_ff @(posedge clk) begin
		if (memWrite && isOutAddr) begin
			outValue <= writeData;
		end
	end

	readWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(memRead && memWrite));

endmodule

//--- memory/mainMem.sv
`include "cpuConsts.svh"

module mainMem import isaPkg::*, datapathPkg::*; (
	input  logic     clk,
	input  logic     loadEn,
	input  instrAddr loadAddr,
	input  instrWord loadData,
	input  instrAddr pc,
	output instrWord instr,
	input  dataAddr  ramAddr,
	input  dataWord  ramWriteData,
	input  logic     ramWriteEn,
	output dataWord  ramReadData
);

	instrWord instrMem [1 << `INSTR_ADDR_BITS];
	dataWord  dataRam [1 << `DATA_ADDR_BITS];

	////////////////////////////////////////
	// Instruction side
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (loadEn) begin
			instrMem[loadAddr] <= loadData;
		end
	end

	// Fetch is combinational
	assign instr = instrMem[pc];

	////////////////////////////////////////
	// Data side
	////////////////////////////////////////

	// Read before write with data one cycle after the address
	always_ff @(posedge clk) begin
		if (ramWriteEn) begin
			dataRam[ramAddr] <= ramWriteData;
		end
		ramReadData <= dataRam[ramAddr];
	end

endmodule

//--- logic/cpuTop.sv
module cpuTop import isaPkg::*, datapathPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     loadEn,
	input  instrAddr loadAddr,
	input  instrWord loadData,
	input  dataWord  inValue,
	output dataWord  outValue,
	output logic     outStrobe,
	output logic     halted
);

	instrWord    instr;
	instrAddr    pc;
	instrAddr    jumpTarget;
	regIndex     readSel1;
	regIndex     readSel2;
	regIndex     destSel;
	wbSourceType wbSource;
	aluOpType    aluOp;
	flagBits     flags;
	dataWord     immediate;
	dataWord     readData1;
	dataWord     readData2;
	dataWord     aluB;
	dataWord     aluResult;
	dataWord     writeData;
	dataWord     memReadData;
	dataWord     ramWriteData;
	dataWord     ramReadData;
	dataAddr     ramAddr;
	logic        regWriteEn;
	logic        flagWrite;
	logic        memRead;
	logic        memWrite;
	logic        hold;
	logic        jumpEn;
	logic        callEn;
	logic        retEn;
	logic        ramWriteEn;
	logic        loadWriteEn;

	// Program load only while the core sits in reset
	assign loadWriteEn = loadEn && !rstN;

	// ADDI takes the immediate as second operand
	assign aluB = (opcode'(instr[17:14]) == ADDI) ? immediate : readData2;

	////////////////////////////////////////
	// Writeback select
	////////////////////////////////////////

	always_comb begin
		unique case (wbSource)
			wbAlu:       writeData = aluResult;
			wbImmediate: writeData = immediate;
			wbMemory:    writeData = memReadData;
			default:     writeData = aluResult;
		endcase
	end

	controlUnit control (.clk(clk), .rstN(rstN), .instr(instr), .flags(flags),
		.readSel1(readSel1), .readSel2(readSel2), .destSel(destSel),
		.regWriteEn(regWriteEn), .wbSource(wbSource), .immediate(immediate),
		.aluOp(aluOp), .flagWrite(flagWrite), .memRead(memRead), .memWrite(memWrite),
		.hold(hold), .jumpEn(jumpEn), .callEn(callEn), .retEn(retEn),
		.jumpTarget(jumpTarget), .halted(halted));

	registerFile regFile (.clk(clk), .rstN(rstN), .readSel1(readSel1),
		.readSel2(readSel2), .readData1(readData1), .readData2(readData2),
		.destSel(destSel), .writeEn(regWriteEn), .writeData(writeData));

	executeUnit alu (.clk(clk), .rstN(rstN), .a(readData1), .b(aluB), .aluOp(aluOp),
		.flagWrite(flagWrite), .result(aluResult), .flags(flags));

	fetchUnit fetch (.clk(clk), .rstN(rstN), .hold(hold), .jumpEn(jumpEn),
		.callEn(callEn), .retEn(retEn), .jumpTarget(jumpTarget), .pc(pc));

	// Address from rs, store data from rt
	memoryController memCtrl (.clk(clk), .rstN(rstN), .accessAddr(readData1),
		.writeData(readData2), .memRead(memRead), .memWrite(memWrite),
		.ramReadData(ramReadData), .inValue(inValue), .ramAddr(ramAddr),
		.ramWriteData(ramWriteData), .ramWriteEn(ramWriteEn), .readData(memReadData),
		.outValue(outValue), .outStrobe(outStrobe));

	mainMem memory (.clk(clk), .loadEn(loadWriteEn), .loadAddr(loadAddr),
		.loadData(loadData), .pc(pc), .instr(instr), .ramAddr(ramAddr),
		.ramWriteData(ramWriteData), .ramWriteEn(ramWriteEn), .ramReadData(ramReadData));

endmodule

//--- testbench/clockGen.sv
module clockGen (
	input  logic holdReset,
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 1ps;

	// Edges counted since holdReset dropped
	int resetCycles;

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		resetCycles = 0;
		forever #50 clk = ~clk;
	end

	// Reset stays low for four edges after the hold request ends
	always @(posedge clk) begin
		if (holdReset) begin
			resetCycles <= 0;
			rstN <= 1'b0;
		end else if (resetCycles < 3) begin
			resetCycles <= resetCycles + 1;
		end else begin
			rstN <= 1'b1;
		end
	end

endmodule

//--- testbench/cpuTb.sv
`include "cpuConsts.svh"

module cpuTb import isaPkg::*, datapathPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PROGRAM_COUNT = 8;
	localparam int SEGMENTS = 5;
	localparam int HALT_TIMEOUT = 5000;

	logic     clk;
	logic     rstN;
	logic     holdReset;
	logic     loadEn;
	instrAddr loadAddr;
	instrWord loadData;
	dataWord  inValue;
	dataWord  outValue;
	logic     outStrobe;
	logic     halted;

	logic [31:0] rngState;
	instrWord    progMem [256];
	int          progLen;
	dataWord     expOut [256];
	int          expCount;
	dataWord     gotOut [256];
	int          gotCount;

	clockGen clocks (.holdReset(holdReset), .clk(clk), .rstN(rstN));

	cpuTop dut (.clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadData(loadData), .inValue(inValue), .outValue(outValue),
		.outStrobe(outStrobe), .halted(halted));

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Working registers are r0..r7
	function automatic logic [3:0] randomReg();
		return 4'(nextRandom() % 8);
	endfunction

	task automatic failRun(input string message);
		$display("%s", message);
		$display("Errors found");
		$fatal(1, "Simulation stopped on first failure");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			failRun($sformatf("Error in %s: expected %0h, actual %0h", testName, expected,
				actual));
		end
	endtask

	function automatic instrWord regForm(logic [3:0] op, logic [3:0] rd, logic [3:0] rs,
			logic [3:0] rt);
		return {op, rd, rs, rt, 2'b00};
	endfunction

	function automatic instrWord immForm(logic [3:0] op, logic [3:0] rd, logic [9:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic void emit(instrWord word);
		progMem[progLen] = word;
		progLen++;
	endfunction

	////////////////////////////////////////
	// Program generation
	////////////////////////////////////////

	task automatic aluSegment();
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [3:0] op;
		logic [9:0] imm;
		int         choice;
		for (int j = 0; j < 3; j++) begin
			rd = randomReg();
			rs = randomReg();
			rt = randomReg();
			op = 4'(nextRandom() % 7);
			imm = 10'(nextRandom());
			choice = int'(nextRandom() % 3);
			if (choice == 0) begin
				emit(immForm(LDI, rd, imm));
			end else if (choice == 1) begin
				emit(immForm(ADDI, rd, imm));
			end else begin
				emit(regForm(op, rd, rs, rt));
			end
			emit(regForm(ST, 4'd0, 4'd15, rd));
		end
	endtask

	// Two outputs skipped when the branch is taken
	task automatic branchSegment();
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [3:0] op;
		logic [1:0] cond;
		logic [3:0] skipA;
		logic [3:0] skipB;
		int         target;
		rd = randomReg();
		rs = randomReg();
		rt = (nextRandom() % 4 == 0) ? rs : randomReg();
		op = (nextRandom() % 2 == 0) ? SUB : ADD;
		cond = 2'(nextRandom() % 4);
		skipA = randomReg();
		skipB = randomReg();
		emit(regForm(op, rd, rs, rt));
		target = progLen + 3;
		emit({BR, cond, 2'b00, 10'(target)});
		emit(regForm(ST, 4'd0, 4'd15, skipA));
		emit(regForm(ST, 4'd0, 4'd15, skipB));
		emit(regForm(ST, 4'd0, 4'd15, rd));
	endtask

	task automatic memorySegment();
		logic [3:0] data;
		int         start;
		int         step;
		int         k;
		for (int j = 0; j < 3; j++) begin
			data = randomReg();
			emit(immForm(LDI, 4'(8 + j), 10'(nextRandom() % 256)));
			emit(regForm(ST, 4'd0, 4'(8 + j), data));
		end
		// Read back in a shuffled order
		start = int'(nextRandom() % 3);
		step = (nextRandom() % 2 == 0) ? 1 : 2;
		for (int j = 0; j < 3; j++) begin
			k = (start + j * step) % 3;
			emit(regForm(LD, 4'(j), 4'(8 + k), 4'd0));
			emit(regForm(ST, 4'd0, 4'd15, 4'(j)));
		end
		emit(regForm(LD, 4'd3, 4'd13, 4'd0));
		emit(regForm(ST, 4'd0, 4'd15, 4'd3));
		emit(regForm(LD, 4'd4, 4'd12, 4'd0));
		emit(regForm(ST, 4'd0, 4'd15, 4'd4));
		// No strobe expected for these two
		data = randomReg();
		emit(regForm(ST, 4'd0, 4'd12, data));
		data = randomReg();
		emit(regForm(ST, 4'd0, 4'd13, data));
	endtask

	task automatic buildProgram(input int programIndex);
		int         kind;
		int         callSite;
		logic [3:0] reg1;
		logic [9:0] imm;
		progLen = 0;
		callSite = -1;
		// r15 = FF00, r13 = FF01, r12 = another word of the I/O page
		emit(immForm(LDI, 4'd14, 10'd6));
		emit(immForm(LDI, 4'd15, 10'h3FC));
		emit(regForm(SHL, 4'd15, 4'd15, 4'd14));
		emit(immForm(LDI, 4'd13, 10'd1));
		emit(regForm(ADD, 4'd13, 4'd15, 4'd13));
		emit(immForm(LDI, 4'd12, 10'd2 + 10'(nextRandom() % 254)));
		emit(regForm(ADD, 4'd12, 4'd15, 4'd12));
		for (int r = 0; r < 8; r++) begin
			emit(immForm(LDI, 4'(r), 10'(nextRandom())));
		end
		for (int s = 0; s < SEGMENTS; s++) begin
			kind = (s == 0) ? programIndex % 4 : int'(nextRandom() % 4);
			if (kind == 3 && callSite >= 0) begin
				kind = 0;
			end
			case (kind)
				0: aluSegment();
				1: branchSegment();
				2: memorySegment();
				default: begin
					// Patched once the subroutine address is known
					callSite = progLen;
					emit(immForm(NOP, 4'd0, 10'd0));
					reg1 = randomReg();
					emit(regForm(ST, 4'd0, 4'd15, reg1));
				end
			endcase
		end
		emit(immForm(HALT, 4'd0, 10'd0));
		if (callSite >= 0) begin
			progMem[callSite] = {CALL, 4'd0, 10'(progLen)};
			reg1 = randomReg();
			imm = 10'(nextRandom());
			emit(immForm(LDI, reg1, imm));
			emit(regForm(ST, 4'd0, 4'd15, reg1));
			emit(immForm(RET, 4'd0, 10'd0));
		end
	endtask

	////////////////////////////////////////
	// Instruction-set model
	////////////////////////////////////////

	task automatic modelProgram(input dataWord inWord);
		dataWord     regs [16];
		dataWord     ram [256];
		dataWord     a;
		dataWord     b;
		dataWord     addr;
		logic [16:0] wide;
		logic        carry;
		logic        zero;
		logic        taken;
		logic        running;
		instrWord    w;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  rt;
		int          pc;
		int          retAddr;
		int          steps;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		carry = 1'b0;
		zero = 1'b0;
		expCount = 0;
		pc = 0;
		retAddr = 0;
		steps = 0;
		running = 1'b1;
		while (running) begin
			if (steps > 4096 || pc >= progLen) begin
				failRun("Reference model left the generated program");
			end
			steps++;
			w = progMem[pc];
			rd = w[13:10];
			rs = w[9:6];
			rt = w[5:2];
			pc = pc + 1;
			case (w[17:14])
				ADD, SUB, AND, OR, XOR, SHL, SHR, ADDI: begin
					a = (w[17:14] == ADDI) ? regs[rd] : regs[rs];
					b = (w[17:14] == ADDI) ? {{6{w[9]}}, w[9:0]} : regs[rt];
					carry = 1'b0;
					case (w[17:14])
						ADD, ADDI: begin
							wide = {1'b0, a} + {1'b0, b};
							carry = wide[16];
						end
						SUB: begin
							wide = {1'b0, a - b};
							carry = (a < b);
						end
						AND: wide = {1'b0, a & b};
						OR:  wide = {1'b0, a | b};
						XOR: wide = {1'b0, a ^ b};
						SHL: wide = {1'b0, a << b[3:0]};
						default: wide = {1'b0, a >> b[3:0]};
					endcase
					regs[rd] = wide[15:0];
					zero = (wide[15:0] == 16'd0);
				end
				LDI: regs[rd] = {6'b0, w[9:0]};
				LD: begin
					addr = regs[rs];
					if (addr == `IO_IN_ADDR) begin
						regs[rd] = inWord;
					end else if (addr[15:8] == `IO_PAGE) begin
						regs[rd] = '0;
					end else begin
						regs[rd] = ram[addr[7:0]];
					end
				end
				ST: begin
					addr = regs[rs];
					if (addr == `IO_OUT_ADDR) begin
						expOut[expCount] = regs[rt];
						expCount++;
					end else if (addr[15:8] != `IO_PAGE) begin
						ram[addr[7:0]] = regs[rt];
					end
				end
				BR: begin
					case (branchCond'(w[13:12]))
						condAlways:  taken = 1'b1;
						condZero:    taken = zero;
						condNotZero: taken = !zero;
						default:     taken = carry;
					endcase
					if (taken) begin
						pc = int'(w[9:0]);
					end
				end
				CALL: begin
					retAddr = pc;
					pc = int'(w[9:0]);
				end
				RET:  pc = retAddr;
				HALT: running = 1'b0;
				default: ;
			endcase
		end
	endtask

	////////////////////////////////////////
	// Run and check
	////////////////////////////////////////

	// Output port monitor
	always @(negedge clk) begin
		if (rstN && outStrobe) begin
			if (halted) begin
				failRun("Output strobe seen while the core was halted");
			end
			if (gotCount < 256) begin
				gotOut[gotCount] = outValue;
			end
			gotCount++;
		end
	end

	task automatic runProgram(input int programIndex);
		dataWord inWord;
		int      cycles;
		buildProgram(programIndex);
		inWord = dataWord'(nextRandom());
		modelProgram(inWord);
		@(posedge clk);
		holdReset <= 1'b1;
		@(posedge clk);
		inValue <= inWord;
		for (int i = 0; i < progLen; i++) begin
			loadEn <= 1'b1;
			loadAddr <= instrAddr'(i);
			loadData <= progMem[i];
			@(posedge clk);
		end
		loadEn <= 1'b0;
		holdReset <= 1'b0;
		gotCount = 0;
		cycles = 0;
		while (!rstN && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (!rstN) begin
			failRun("Reset was not released after the program load");
		end
		checkValue($sformatf("program %0d halted after reset", programIndex), 0, halted);
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			failRun($sformatf("Program %0d never reached HALT", programIndex));
		end
		// A few idle cycles to catch late strobes
		repeat (4) @(negedge clk);
		checkValue($sformatf("program %0d halted stays high", programIndex), 1, halted);
		checkValue($sformatf("program %0d strobe count", programIndex), expCount, gotCount);
		for (int i = 0; i < expCount; i++) begin
			checkValue($sformatf("program %0d output %0d", programIndex, i), expOut[i],
				gotOut[i]);
		end
	endtask

	initial begin
		rngState = 32'd71771;
		holdReset = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		inValue = '0;
		gotCount = 0;
		for (int p = 0; p < PROGRAM_COUNT; p++) begin
			runProgram(p);
		end
		$display("No errors");
		$finish;
	end

endmodule

//--- cpu.f
+incdir+common
common/isaPkg.sv
common/datapathPkg.sv
control/controlUnit.sv
logic/executeUnit.sv
logic/registerFile.sv
logic/fetchUnit.sv
memory/memoryController.sv
memory/mainMem.sv
logic/cpuTop.sv
testbench/clockGen.sv
testbench/cpuTb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/datapathPkg.sv
      - control/controlUnit.sv
      - logic/executeUnit.sv
      - logic/registerFile.sv
      - logic/fetchUnit.sv
      - memory/memoryController.sv
      - memory/mainMem.sv
      - logic/cpuTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/clockGen.sv
      - testbench/cpuTb.sv
